//--- Makefile
# Verilator simulation of the I2C register slave
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP      = I2cSlaveTb
FILELIST = i2cRegSlave.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- i2cRegSlave.f
+incdir+source
+incdir+tb
source/i2cSlavePkg.sv
source/I2cBusDecode.sv
source/I2cXferExecute.sv
source/I2cRegResult.sv
source/I2cSlaveTop.sv
tb/I2cSlaveTb.sv

//--- source/I2cBusDecode.sv
/*
 * SCL/SDA bus condition decode. No glitch filter beyond the synchronizer.
 * Strobes lag the pins by I2C_SYNC_DEPTH + 1 cycles.
 */
`default_nettype none
`include "i2cSlave_consts.svh"

module I2cBusDecode
(
	input  wire  iCLK,
	input  wire  iRST,
	input  wire  iI2cScl,
	input  wire  iI2cSda,
	output logic sclRise,
	output logic sclFall,
	output logic startDet,
	output logic stopDet,
	output logic sdaBit,
	output logic busActive
);

	logic [`I2C_SYNC_DEPTH-1:0] sclSync;	// Synchronizer chains
	logic [`I2C_SYNC_DEPTH-1:0] sdaSync;
	logic sclNow, sdaNow;	// Synchronized levels
	logic sclLast, sdaLast;	// One sample older

	assign sclNow = sclSync[`I2C_SYNC_DEPTH-1];
	assign sdaNow = sdaSync[`I2C_SYNC_DEPTH-1];

	// Pins idle high, so reset to high avoids a false edge
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			sclSync <= '1;
			sdaSync <= '1;
			sclLast <= 1'b1;
			sdaLast <= 1'b1;
		end
		else
		begin
			sclSync <= {sclSync[`I2C_SYNC_DEPTH-2:0], iI2cScl};
			sdaSync <= {sdaSync[`I2C_SYNC_DEPTH-2:0], iI2cSda};
			sclLast <= sclNow;
			sdaLast <= sdaNow;
		end
	end

	// Registered edge and condition strobes
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			sclRise  <= 1'b0;
			sclFall  <= 1'b0;
			startDet <= 1'b0;
			stopDet  <= 1'b0;
		end
		else
		begin
			sclRise  <= sclNow & ~sclLast;
			sclFall  <= ~sclNow & sclLast;
			startDet <= sclNow & sclLast & sdaLast & ~sdaNow;	// SDA falls, SCL high
			stopDet  <= sclNow & sclLast & ~sdaLast & sdaNow;	// SDA rises, SCL high
		end
	end

	// Bus ownership between START and STOP
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			busActive <= 1'b0;
		else if (stopDet)
			busActive <= 1'b0;
		else if (startDet)
			busActive <= 1'b1;
	end

	// Same age as the strobes
	assign sdaBit = sdaLast;

endmodule

`default_nettype wire

//--- source/I2cRegResult.sv
/*
 * Byte register file with an auto-incrementing pointer.
 * The pointer wraps at I2C_REG_COUNT. Each write is echoed on oDd/oAdrs/oVd.
 */
`default_nettype none
`include "i2cSlave_consts.svh"

module I2cRegResult
(
	input  wire                       iCLK,
	input  wire                       iRST,
	input  i2cSlavePkg::xferOpT       op,
	input  wire                       ptrLoad,
	input  wire  [`I2C_PTR_WIDTH-1:0] ptrData,
	input  wire                       wrStb,
	input  wire  [7:0]                wrData,
	input  wire                       rdStb,
	output logic [7:0]                rdData,
	output logic [7:0]                oDd,
	output logic [`I2C_PTR_WIDTH-1:0] oAdrs,
	output logic                      oVd
);

	typedef logic [`I2C_PTR_WIDTH-1:0] ptrT;
	localparam ptrT LastPtr = ptrT'(`I2C_REG_COUNT - 1);	// Wrap point

	logic [7:0] regFile [`I2C_REG_COUNT];
	ptrT        ptr;
	ptrT        ptrNext;
	logic       advance;

	// Read strobes only count during a read
	assign advance = wrStb | (rdStb & (op == i2cSlavePkg::opRead));
	assign ptrNext = (ptr == LastPtr) ? '0 : ptr + 1'b1;

	always_ff @(posedge iCLK)
	begin
		oVd <= 1'b0;
		if (iRST)
		begin
			ptr <= '0;
			for (int i = 0; i < `I2C_REG_COUNT; i++)
				regFile[i] <= 8'd0;
		end
		else
		begin
			if (ptrLoad)
				ptr <= ptrData;
			else if (advance)
				ptr <= ptrNext;
			if (wrStb)
			begin
				regFile[ptr] <= wrData;
				oDd          <= wrData;	// Echo of the written byte
				oAdrs        <= ptr;
				oVd          <= 1'b1;
			end
		end
	end

	// Byte at the pointer, ready for the next shift-out
	assign rdData = regFile[ptr];

endmodule

`default_nettype wire

//--- source/I2cSlaveTop.sv
/*
 * I2C register slave top. SCL is input only, no clock stretching.
 * SDA is open drain: oI2cSda is tied low and oI2cSdaOe pulls the line.
 * SCL phases must last well over 8 iCLK periods.
 */
`default_nettype none
`include "i2cSlave_consts.svh"

module I2cSlaveTop
(
	input  wire                       iCLK,
	input  wire                       iRST,
	input  wire                       iI2cScl,
	input  wire                       iI2cSda,
	output logic                      oI2cSda,
	output logic                      oI2cSdaOe,
	input  wire  [6:0]                iSlaveAdrs,
	output logic [7:0]                oDd,
	output logic [`I2C_PTR_WIDTH-1:0] oAdrs,
	output logic                      oVd
);

	logic sclRise, sclFall;	// Decode strobes
	logic startDet, stopDet;
	logic sdaBit;
	logic busActive;
	i2cSlavePkg::xferOpT op;
	logic ptrLoad;
	logic [`I2C_PTR_WIDTH-1:0] ptrData;
	logic wrStb;
	logic [7:0] wrData;
	logic rdStb;
	logic [7:0] rdData;

	I2cBusDecode I2cBusDecode_i
	(
		.iCLK      (iCLK),
		.iRST      (iRST),
		.iI2cScl   (iI2cScl),
		.iI2cSda   (iI2cSda),
		.sclRise   (sclRise),
		.sclFall   (sclFall),
		.startDet  (startDet),
		.stopDet   (stopDet),
		.sdaBit    (sdaBit),
		.busActive (busActive)
	);

	I2cXferExecute I2cXferExecute_i
	(
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iSlaveAdrs (iSlaveAdrs),
		.sclRise    (sclRise),
		.sclFall    (sclFall),
		.startDet   (startDet),
		.stopDet    (stopDet),
		.sdaBit     (sdaBit),
		.busActive  (busActive),
		.rdData     (rdData),
		.op         (op),
		.ptrLoad    (ptrLoad),
		.ptrData    (ptrData),
		.wrStb      (wrStb),
		.wrData     (wrData),
		.rdStb      (rdStb),
		.sdaOe      (oI2cSdaOe)	// Registered in execute
	);

	I2cRegResult I2cRegResult_i
	(
		.iCLK    (iCLK),
		.iRST    (iRST),
		.op      (op),
		.ptrLoad (ptrLoad),
		.ptrData (ptrData),
		.wrStb   (wrStb),
		.wrData  (wrData),
		.rdStb   (rdStb),
		.rdData  (rdData),
		.oDd     (oDd),
		.oAdrs   (oAdrs),
		.oVd     (oVd)
	);

	// Only ever drives low
	assign oI2cSda = 1'b0;

endmodule

`default_nettype wire

//--- source/I2cXferExecute.sv
/*
 * Byte-level I2C slave transfer FSM. 7-bit addressing only, no general call.
 * SDA changes only after a decoded SCL fall; SCL is never held low.
 * Repeated START restarts the address phase.
 */
`default_nettype none
`include "i2cSlave_consts.svh"

module I2cXferExecute
(
	input  wire                     iCLK,
	input  wire                     iRST,
	input  wire  [6:0]              iSlaveAdrs,
	input  wire                     sclRise,
	input  wire                     sclFall,
	input  wire                     startDet,
	input  wire                     stopDet,
	input  wire                     sdaBit,
	input  wire                     busActive,
	input  wire  [7:0]              rdData,
	output i2cSlavePkg::xferOpT     op,
	output logic                    ptrLoad,
	output logic [`I2C_PTR_WIDTH-1:0] ptrData,
	output logic                    wrStb,
	output logic [7:0]              wrData,
	output logic                    rdStb,
	output logic                    sdaOe
);

	i2cSlavePkg::xferStateT state;
	logic [3:0] bitCnt;		// SCL rises in current byte
	logic [7:0] rxShift;	// MSB-first deserializer
	logic [7:0] txShift;	// Read byte being sent
	logic       ptrLoaded;	// Pointer byte seen in this write
	logic [7:0] rxByte;

	// Byte as completed by the current rise
	assign rxByte = {rxShift[6:0], sdaBit};

	always_ff @(posedge iCLK)
	begin
		ptrLoad <= 1'b0;	// Strobes default low
		wrStb   <= 1'b0;
		rdStb   <= 1'b0;
		if (iRST)
		begin
			state     <= i2cSlavePkg::idle;
			bitCnt    <= 4'd0;
			sdaOe     <= 1'b0;
			ptrLoaded <= 1'b0;
			op        <= i2cSlavePkg::opWrite;
		end
		else if (startDet)
		begin
			state     <= i2cSlavePkg::addr;	// Also covers repeated START
			bitCnt    <= 4'd0;
			sdaOe     <= 1'b0;
			ptrLoaded <= 1'b0;
		end
		else if (stopDet || !busActive)
		begin
			state <= i2cSlavePkg::idle;	// Release SDA at once
			sdaOe <= 1'b0;
		end
		else
		begin
			if (sclRise)
			begin
				rxShift <= rxByte;
				bitCnt  <= bitCnt + 4'd1;
			end
			case (state)
				i2cSlavePkg::addr:
					if (sclRise && bitCnt == 4'd7)
					begin
						bitCnt <= 4'd0;
						if (rxByte[7:1] == iSlaveAdrs)
						begin
							op    <= i2cSlavePkg::xferOpT'(rxByte[0]);	// R/W bit
							state <= i2cSlavePkg::addrAck;
						end
						else
							state <= i2cSlavePkg::idle;	// Not us, stay released
					end
				i2cSlavePkg::addrAck:
					if (sclFall)
					begin
						if (!sdaOe)
							sdaOe <= 1'b1;	// ACK low for the ninth clock
						else if (op == i2cSlavePkg::opRead)
						begin
							txShift <= rdData;	// First byte at pointer
							sdaOe   <= ~rdData[7];
							rdStb   <= 1'b1;	// Pointer moves to next byte
							bitCnt  <= 4'd0;
							state   <= i2cSlavePkg::rdByte;
						end
						else
						begin
							sdaOe  <= 1'b0;
							bitCnt <= 4'd0;
							state  <= i2cSlavePkg::wrByte;
						end
					end
				i2cSlavePkg::wrByte:
					if (sclRise && bitCnt == 4'd7)
					begin
						bitCnt <= 4'd0;
						state  <= i2cSlavePkg::wrAck;
						if (ptrLoaded)
						begin
							wrStb  <= 1'b1;
							wrData <= rxByte;
						end
						else
						begin
							ptrLoad   <= 1'b1;	// First data byte is the pointer
							ptrData   <= rxByte[`I2C_PTR_WIDTH-1:0];
							ptrLoaded <= 1'b1;
						end
					end
				i2cSlavePkg::wrAck:
					if (sclFall)
					begin
						if (!sdaOe)
							sdaOe <= 1'b1;
						else
						begin
							sdaOe  <= 1'b0;	// ACK clock done
							bitCnt <= 4'd0;
							state  <= i2cSlavePkg::wrByte;
						end
					end
				i2cSlavePkg::rdByte:
					if (sclFall)
					begin
						if (bitCnt == 4'd8)
						begin
							sdaOe  <= 1'b0;	// Let master drive ACK
							bitCnt <= 4'd0;
							state  <= i2cSlavePkg::rdAck;
						end
						else
						begin
							sdaOe   <= ~txShift[6];	// Open drain, pull for a 0
							txShift <= {txShift[6:0], 1'b0};
						end
					end
				i2cSlavePkg::rdAck:
					if (sclRise && sdaBit)
						state <= i2cSlavePkg::idle;	// NACK ends the read
					else if (sclFall)
					begin
						txShift <= rdData;
						sdaOe   <= ~rdData[7];
						rdStb   <= 1'b1;
						bitCnt  <= 4'd0;
						state   <= i2cSlavePkg::rdByte;
					end
				default:
					state <= i2cSlavePkg::idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/i2cSlavePkg.sv
/*
 * Shared types for the I2C register slave.
 * The opcode encoding follows the R/W bit of the address byte.
 */
`default_nettype none

package i2cSlavePkg;

	// Transfer FSM states
	typedef enum logic [2:0]
	{
		idle,		// Bus free or not addressed
		addr,		// Shifting in the address byte
		addrAck,	// Driving ACK for the address
		wrByte,		// Receiving pointer or data byte
		wrAck,		// Driving ACK for a written byte
		rdByte,		// Shifting out a register byte
		rdAck		// Sampling master ACK/NACK
	} xferStateT;

	// Transfer type from the R/W bit
	typedef enum logic
	{
		opWrite = 1'b0,
		opRead  = 1'b1
	} xferOpT;

endpackage

`default_nettype wire

//--- source/i2cSlave_consts.svh
/*
 * Register file and synchronizer sizing for the I2C register slave.
 * I2C_PTR_WIDTH must be wide enough to index I2C_REG_COUNT entries.
 * I2C_SYNC_DEPTH is at least 2.
 */
`ifndef I2C_SLAVE_CONSTS_SVH
`define I2C_SLAVE_CONSTS_SVH

// Byte registers behind the slave
`define I2C_REG_COUNT 16

// Register pointer width, log2 of the count
`define I2C_PTR_WIDTH 4

// Input synchronizer flops per pin
`define I2C_SYNC_DEPTH 2

`endif

//--- tb/i2cMasterTasks.svh
/*
 * Bit-level I2C master tasks, included inside the testbench module.
 * Each task starts and ends with SCL just driven low, except busStart.
 * Needs iCLK, sclDrv, sdaDrv, sclBus, sdaBus and failRun in scope.
 */
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

localparam int PhaseCycles = 10;	// iCLK cycles per SCL phase
localparam int SclTimeout  = 40;

task automatic waitCycles(input int n);
	repeat (n) @(posedge iCLK);
endtask

// No stretching in the DUT, but the bus level is still checked
task automatic waitSclLevel(input logic level);
	int count;
	count = 0;
	while (sclBus !== level)
	begin
		@(posedge iCLK);
		count++;
		if (count > SclTimeout)
		begin
			$display("Timed out: SCL did not reach %0b after %0d cycles", level, count);
			failRun();
		end
	end
endtask

// One SCL clock, SDA set mid-low, sampled mid-high
task automatic clockBit(input logic txBit, output logic rxBit);
	waitCycles(PhaseCycles / 2);
	sdaDrv <= txBit;	// 1 releases the line
	waitCycles(PhaseCycles / 2);
	sclDrv <= 1'b1;
	waitSclLevel(1'b1);
	waitCycles(PhaseCycles / 2);
	@(negedge iCLK);
	rxBit = sdaBus;	// Stable away from the DUT's edge
	waitCycles(PhaseCycles / 2);
	sclDrv <= 1'b0;
endtask

task automatic busStart();
	waitSclLevel(1'b1);
	@(posedge iCLK);
	sdaDrv <= 1'b0;	// SDA falls with SCL high
	waitCycles(PhaseCycles);
	sclDrv <= 1'b0;
endtask

task automatic busStop();
	waitCycles(PhaseCycles / 2);
	sdaDrv <= 1'b0;
	waitCycles(PhaseCycles / 2);
	sclDrv <= 1'b1;
	waitSclLevel(1'b1);
	waitCycles(PhaseCycles);
	sdaDrv <= 1'b1;	// SDA rises with SCL high
	waitCycles(PhaseCycles);
endtask

// MSB first, ninth clock samples the slave's ACK
task automatic writeByte(input logic [7:0] data, output logic acked);
	logic rx;
	for (int i = 7; i >= 0; i--)
		clockBit(data[i], rx);
	clockBit(1'b1, rx);
	acked = ~rx;
endtask

task automatic readByte(output logic [7:0] data, input logic ackIt);
	logic rx;
	for (int i = 7; i >= 0; i--)
	begin
		clockBit(1'b1, rx);
		data[i] = rx;
	end
	clockBit(~ackIt, rx);	// Low for ACK, released for NACK
endtask

`endif

//--- tb/I2cSlaveTb.sv
/*
 * Testbench for I2cSlaveTop with an open-drain SDA model and a register model.
 * Stops at the first mismatch or timeout.
 */
`default_nettype none
`include "i2cSlave_consts.svh"

module I2cSlaveTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [6:0] SlaveAdrs = 7'h42;
	localparam int VdTimeout = 100;

	logic iCLK;
	logic iRST;
	logic sclDrv;	// Master side of the bus
	logic sdaDrv;
	logic [6:0] slaveAdrs;
	wire sclBus;
	wire sdaBus;
	wire oI2cSda;
	wire oI2cSdaOe;
	wire [7:0] oDd;
	wire [`I2C_PTR_WIDTH-1:0] oAdrs;
	wire oVd;

	logic [31:0] lfsr;
	logic [7:0] refRegs [`I2C_REG_COUNT];	// Expected register contents
	logic [11:0] vdQueue [$];	// {oAdrs, oDd} per oVd pulse
	logic [3:0] firstPtr;

	// Pulled-up wire, either side can pull low
	assign sclBus = sclDrv;
	assign sdaBus = sdaDrv & ~(oI2cSdaOe & ~oI2cSda);

	I2cSlaveTop I2cSlaveTop_i
	(
		.iCLK       (iCLK),
		.iRST       (iRST),
		.iI2cScl    (sclBus),
		.iI2cSda    (sdaBus),
		.oI2cSda    (oI2cSda),
		.oI2cSdaOe  (oI2cSdaOe),
		.iSlaveAdrs (slaveAdrs),
		.oDd        (oDd),
		.oAdrs      (oAdrs),
		.oVd        (oVd)
	);

	always #4 iCLK = ~iCLK;

	// Collect written-byte strobes away from the clock edge
	always @(negedge iCLK)
		if (!iRST && oVd)
			vdQueue.push_back({oAdrs, oDd});

	task automatic failRun();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual)
		else
		begin
			$display("ERROR time %0t %s expected %h actual %h", $time, name, expected, actual);
			failRun();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	`include "i2cMasterTasks.svh"

	task automatic waitVd(output logic [11:0] entry);
		int count;
		count = 0;
		while (vdQueue.size() == 0)
		begin
			@(posedge iCLK);
			count++;
			if (count > VdTimeout)
			begin
				$display("Timed out: no written-byte strobe after %0d cycles", count);
				failRun();
			end
		end
		entry = vdQueue.pop_front();
	endtask

	// SDA released and no write strobe for a stretch of cycles
	task automatic checkQuiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge iCLK);
			checkValue("oI2cSdaOe", 32'd0, 32'(oI2cSdaOe));
			checkValue("oVd", 32'd0, 32'(oVd));
		end
	endtask

	task automatic addressSlave(input logic [6:0] adrs, input logic rw, input logic expAck);
		logic acked;
		busStart();
		writeByte({adrs, rw}, acked);
		checkValue("addressAck", 32'(expAck), 32'(acked));
	endtask

	// One data byte, checked against its oVd echo
	task automatic writeChecked(input int adrs);
		logic acked;
		logic [7:0] data;
		logic [11:0] entry;
		data = 8'(randomBits(8));
		writeByte(data, acked);
		checkValue("dataAck", 32'd1, 32'(acked));
		waitVd(entry);
		checkValue("oAdrs", 32'(adrs), 32'(entry[11:8]));
		checkValue("oDd", 32'(data), 32'(entry[7:0]));
		refRegs[adrs] = data;
	endtask

	task automatic sendPointer(input logic [3:0] ptr);
		logic acked;
		writeByte({4'(randomBits(4)), ptr}, acked);	// Upper nibble ignored
		checkValue("pointerAck", 32'd1, 32'(acked));
	endtask

	task automatic writeRegs(input logic [3:0] ptr, input int count);
		addressSlave(SlaveAdrs, 1'b0, 1'b1);
		sendPointer(ptr);
		for (int i = 0; i < count; i++)
			writeChecked((int'(ptr) + i) % `I2C_REG_COUNT);
		busStop();
		checkValue("vdQueueSize", 32'd0, 32'(vdQueue.size()));
	endtask

	task automatic readBack(input logic [3:0] ptr, input int count);
		logic [7:0] data;
		addressSlave(SlaveAdrs, 1'b0, 1'b1);
		sendPointer(ptr);
		busStop();
		addressSlave(SlaveAdrs, 1'b1, 1'b1);
		for (int i = 0; i < count; i++)
		begin
			readByte(data, i != count - 1);	// NACK the last one
			checkValue("readData", 32'(refRegs[(int'(ptr) + i) % `I2C_REG_COUNT]),
				32'(data));
		end
		busStop();
		checkQuiet(10);
	endtask

	initial
	begin
		logic rx;
		logic acked;
		iCLK      = 1'b0;
		iRST      = 1'b1;
		sclDrv    = 1'b1;
		sdaDrv    = 1'b1;
		slaveAdrs = SlaveAdrs;
		lfsr      = 32'h7259;
		for (int i = 0; i < `I2C_REG_COUNT; i++)
			refRegs[i] = 8'd0;	// Registers clear on reset
		repeat (2) @(posedge iCLK);
		iRST <= 1'b0;

		// Idle bus after reset
		checkQuiet(50);

		// Foreign address gets NACK and its data bytes write nothing
		addressSlave(SlaveAdrs ^ 7'h01, 1'b0, 1'b0);
		for (int i = 0; i < 2; i++)
		begin
			writeByte(8'(randomBits(8)), acked);
			checkValue("foreignDataAck", 32'd0, 32'(acked));
		end
		busStop();
		checkQuiet(20);
		checkValue("vdQueueSize", 32'd0, 32'(vdQueue.size()));

		// Three bytes from a random pointer
		firstPtr = 4'(randomBits(4));
		writeRegs(firstPtr, 3);

		// Pointer wraps from the last register to 0
		writeRegs(4'd15, 2);

		readBack(firstPtr, 4);

		// STOP in the middle of a data byte
		addressSlave(SlaveAdrs, 1'b0, 1'b1);
		sendPointer(4'd5);
		writeChecked(5);
		for (int i = 0; i < 4; i++)
			clockBit(1'(randomBits(1)), rx);
		busStop();
		checkQuiet(20);

		// Clocks without a new START must not finish the cut byte
		@(posedge iCLK);
		sclDrv <= 1'b0;
		writeByte(8'(randomBits(8)), acked);
		checkValue("strayByteAck", 32'd0, 32'(acked));
		busStop();
		checkQuiet(20);
		checkValue("vdQueueSize", 32'd0, 32'(vdQueue.size()));
		writeRegs(4'(randomBits(4)), 3);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
